// ==== Bender.yml ====
package:
  name: exec_subsystem

sources:
  - verilog/exu_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/reg_file.sv
  - verilog/alu.sv
  - verilog/exu.sv
  - verilog/csr_unit.sv
  - verilog/exec_top.sv
  - target: test
    files:
      - tests/exec_tb.sv

// ==== project.f ====
verilog/exu_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exu.sv
verilog/csr_unit.sv
verilog/exec_top.sv
tests/exec_tb.sv

// ==== tests/exec_golden.mem ====
// kind, instruction or register, pc or value, val, jump_addr, flags, lsu_data
// kind 0 preloads a register and kind 1 runs an instruction
// flag digits are jump_wrong ren wen
0 00000001 fffffff6 00000000 00000000 000 00000000
0 00000002 00000003 00000000 00000000 000 00000000
0 00000003 80000000 00000000 00000000 000 00000000
0 00000004 00000100 00000000 00000000 000 00000000
0 00000005 fffffff6 00000000 00000000 000 00000000
1 40208333 00001000 fffffff3 00001004 000 00000000 // sub x6, x1, x2
1 4021d3b3 00001004 f0000000 00001008 000 00000000 // sra x7, x3, x2
1 0020a433 00001008 00000001 0000100c 000 00000000 // slt x8, x1, x2
1 0020b4b3 0000100c 00000000 00001010 000 00000000 // sltu x9, x1, x2
1 4020d513 00001010 fffffffd 00001014 000 00000000 // srai x10, x1, 2
1 fff08593 00001014 fffffff5 00001018 000 00000000 // addi x11, x1, -1
1 ffb0a613 00001018 00000001 0000101c 000 00000000 // slti x12, x1, -5
1 0f014693 0000101c 000000f3 00001020 000 00000000 // xori x13, x2, 0xf0
1 007304b3 00001020 effffff3 00001024 000 00000000 // add x9, x6, x7
1 abcde737 00001024 abcde000 00001028 000 00000000 // lui x14, 0xabcde
1 12345797 00002000 12347000 00002004 000 00000000 // auipc x15, 0x12345
1 0400036f 00003000 00003004 00003040 100 00000000 // jal x6, +0x40
1 ff9ff3ef 00003100 00003104 000030f8 100 00000000 // jal x7, -8
1 00520467 00003200 00003204 00000104 100 00000000 // jalr x8, 5(x4)
1 00020067 000000fc 00000100 00000100 000 00000000 // jalr x0, 0(x4) lands on pc+4
1 00508863 00004000 00004010 00004010 100 00000000 // beq x1, x5, +16 taken
1 00509863 00004100 00004110 00004104 000 00000000 // bne x1, x5, +16 not taken
1 fe20c0e3 00004200 000041e0 000041e0 100 00000000 // blt x1, x2, -32 taken
1 0020d463 00004400 00004408 00004404 000 00000000 // bge x1, x2, +8 not taken
1 0020f463 00004500 00004508 00004508 100 00000000 // bgeu x1, x2, +8 taken
1 00822483 00005000 00000108 00005004 010 00000000 // lw x9, 8(x4)
1 fe322e23 00005004 000000fc 00005008 001 80000000 // sw x3, -4(x4)
1 30521573 00006000 00000000 00006004 000 00000000 // csrrw x10, mtvec, x4
1 305125f3 00006004 00000100 00006008 000 00000000 // csrrs x11, mtvec, x2
1 30502673 00006008 00000103 0000600c 000 00000000 // csrrs x12, mtvec, x0
1 341716f3 0000600c 00000000 00006010 000 00000000 // csrrw x13, mepc, x14
1 00000073 00007000 00000000 00000103 100 00000000 // ecall
1 30200073 00007100 00000302 00007000 100 00000000 // mret
1 342027f3 00007200 0000000b 00007204 000 00000000 // csrrs x15, mcause, x0

// ==== tests/exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_tb import exu_pkg::*; ();

	localparam int nr_regs   = 16;
	localparam int ridx_w    = $clog2(nr_regs);
	localparam int rec_words = 7;
	localparam int max_recs  = 64;
	localparam logic [31:0] filler_inst = 32'hfffff0b7; // lui x1, 0xfffff

	logic              clock;
	logic              rst_n;
	logic              inst_valid;
	logic              inst_ready;
	inst_t             inst;
	logic [xlen-1:0]   pc_in;
	logic              wb_en;
	logic [ridx_w-1:0] wb_rd;
	logic [xlen-1:0]   wb_data;
	logic              lsu_valid;
	logic              lsu_ready;
	logic              lsu_ren;
	logic              lsu_wen;
	logic [xlen-1:0]   lsu_data;
	logic [xlen-1:0]   val;
	logic [ridx_w-1:0] rd;
	logic [2:0]        funct3;
	logic              reg_wen;
	logic [xlen-1:0]   jump_addr;
	logic              jump_wrong;

	logic [31:0] golden [rec_words*max_recs];
	int          nr_recs;
	int          cycles      = 0;
	int          cycle_limit = 0;
	int          word_errors;
	int          bit_errors;
	int          other_errors;
	logic [31:0] lfsr;

	exec_top #(.nr_regs(nr_regs)) i_dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.inst       (inst),
		.pc_in      (pc_in),
		.wb_en      (wb_en),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.lsu_valid  (lsu_valid),
		.lsu_ready  (lsu_ready),
		.lsu_ren    (lsu_ren),
		.lsu_wen    (lsu_wen),
		.lsu_data   (lsu_data),
		.val        (val),
		.rd         (rd),
		.funct3     (funct3),
		.reg_wen    (reg_wen),
		.jump_addr  (jump_addr),
		.jump_wrong (jump_wrong)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// branches, stores and system ops with rd x0 leave the register file alone
	function automatic logic writes_back(input inst_t w);
		case (w.r_fmt.opcode)
			7'b1100011, 7'b0100011: return 1'b0;
			7'b1110011:             return w.r_fmt.rd != 5'd0;
			default:                return 1'b1;
		endcase
	endfunction

	task automatic random_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v    = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_word(input string what, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			word_errors++;
			$display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errors++;
			$display("FAIL %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// result fields of record r, jump_wrong only in the first result cycle
	task automatic check_results(input int r, input string tag, input logic first);
		logic [31:0] flags;
		inst_t       word;
		logic        wen;
		int          base;
		base  = r * rec_words;
		flags = golden[base+5];
		word  = golden[base+1];
		wen   = writes_back(word);
		check_bit({tag, " lsu_valid"}, lsu_valid, 1'b1);
		check_bit({tag, " inst_ready"}, inst_ready, 1'b0);
		check_word({tag, " val"}, val, golden[base+3]);
		check_word({tag, " jump_addr"}, jump_addr, golden[base+4]);
		check_bit({tag, " jump_wrong"}, jump_wrong, first ? flags[8] : 1'b0);
		check_bit({tag, " lsu_ren"}, lsu_ren, flags[4]);
		check_bit({tag, " lsu_wen"}, lsu_wen, flags[0]);
		if (flags[0])
			check_word({tag, " lsu_data"}, lsu_data, golden[base+6]);
		check_bit({tag, " reg_wen"}, reg_wen, wen);
		if (wen)
			check_word({tag, " rd"}, xlen'(rd), xlen'(word.r_fmt.rd[ridx_w-1:0]));
		check_word({tag, " funct3"}, xlen'(funct3), xlen'(word.r_fmt.funct3));
	endtask

	task automatic preload_reg(input logic [31:0] idx, input logic [31:0] value);
		wb_en   = 1'b1;
		wb_rd   = idx[ridx_w-1:0];
		wb_data = value;
		@(negedge clock);
		wb_en = 1'b0;
	endtask

	task automatic run_inst(input int r);
		inst_t word;
		string tag;
		int    stall;
		word = golden[r*rec_words+1];
		tag  = $sformatf("rec %0d opcode %02h funct3 %0d", r, word.r_fmt.opcode,
			word.r_fmt.funct3);
		inst       = word;
		pc_in      = golden[r*rec_words+2];
		inst_valid = 1'b1;
		while (inst_ready !== 1'b1)
			@(negedge clock);
		@(negedge clock); // taken on the edge just passed
		inst_valid = 1'b0;
		check_results(r, tag, 1'b1); // result one cycle after acceptance
		// back-pressure with another instruction waiting upstream
		random_bits(2, stall);
		for (int i = 0; i < stall; i++) begin
			inst       = filler_inst;
			inst_valid = 1'b1;
			@(negedge clock);
			check_results(r, tag, 1'b0);
		end
		inst_valid = 1'b0;
		lsu_ready  = 1'b1;
		wb_en      = reg_wen; // memory stage writes the result back
		wb_rd      = rd;
		wb_data    = val;
		@(negedge clock);
		lsu_ready = 1'b0;
		wb_en     = 1'b0;
		check_bit({tag, " lsu_valid after transfer"}, lsu_valid, 1'b0);
		check_bit({tag, " inst_ready after transfer"}, inst_ready, 1'b1);
	endtask

	initial begin
		rst_n        = 1'b0;
		inst_valid   = 1'b0;
		inst         = '0;
		pc_in        = '0;
		wb_en        = 1'b0;
		wb_rd        = '0;
		wb_data      = '0;
		lsu_ready    = 1'b0;
		word_errors  = 0;
		bit_errors   = 0;
		other_errors = 0;
		lfsr         = 32'h96a21a54;

		$readmemh("tests/exec_golden.mem", golden);
		nr_recs = 0;
		while (nr_recs < max_recs && !$isunknown(golden[nr_recs*rec_words]))
			nr_recs++;
		if (nr_recs == 0) begin
			other_errors++;
			$display("no records could be read from tests/exec_golden.mem");
		end
		cycle_limit = nr_recs * 20;

		repeat (5) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_bit("inst_ready after reset", inst_ready, 1'b1);
		check_bit("lsu_valid after reset", lsu_valid, 1'b0);
		check_bit("jump_wrong after reset", jump_wrong, 1'b0);

		for (int r = 0; r < nr_recs; r++) begin
			if (golden[r*rec_words] == 32'd0)
				preload_reg(golden[r*rec_words+1], golden[r*rec_words+2]);
			else
				run_inst(r);
		end

		$display("%0d records: %0d word errors, %0d flag errors, %0d other errors",
			nr_recs, word_errors, bit_errors, other_errors);
		if (word_errors + bit_errors + other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import exu_pkg::*; (
	input  logic [nr_classes-1:0] opcode_type,
	input  logic [2:0]            funct3,
	input  logic                  funct7_5,
	input  logic [xlen-1:0]       pc,
	input  logic [xlen-1:0]       src1,
	input  logic [xlen-1:0]       src2,
	input  logic [xlen-1:0]       imm,
	output logic [xlen-1:0]       alu_val,
	output logic [xlen-1:0]       sum
);

	logic [xlen-1:0] loperand;
	logic [xlen-1:0] roperand;
	logic [4:0]      shamt;
	alu_op_t         op;

	// pc relative for auipc, jal and branch targets
	assign loperand = (opcode_type[inst_auipc] | opcode_type[inst_jal] |
		opcode_type[inst_beq]) ? pc :
		opcode_type[inst_lui] ? '0 : src1;
	assign roperand = opcode_type[inst_add] ? src2 : imm;
	assign shamt    = roperand[4:0];
	assign sum      = loperand + roperand;

	always_comb begin
		op = alu_add; // address and target math
		if (opcode_type[inst_addi] | opcode_type[inst_add]) begin
			case (funct3)
				3'b000: op = (opcode_type[inst_add] & funct7_5) ? alu_sub : alu_add;
				3'b001: op = alu_sll;
				3'b010: op = alu_less;
				3'b011: op = alu_uless;
				3'b100: op = alu_xor;
				3'b101: op = funct7_5 ? alu_sra : alu_srl;
				3'b110: op = alu_or;
				3'b111: op = alu_and;
			endcase
		end
	end

	always_comb begin
		case (op)
			alu_sub:   alu_val = loperand - roperand;
			alu_and:   alu_val = loperand & roperand;
			alu_xor:   alu_val = loperand ^ roperand;
			alu_or:    alu_val = loperand | roperand;
			alu_srl:   alu_val = loperand >> shamt;
			alu_sra:   alu_val = $signed(loperand) >>> shamt;
			alu_sll:   alu_val = loperand << shamt;
			alu_less:  alu_val = {31'b0, $signed(loperand) < $signed(roperand)};
			alu_uless: alu_val = {31'b0, loperand < roperand};
			default:   alu_val = sum;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit import exu_pkg::*; (
	input  logic            clock,
	input  logic            rst_n,
	input  logic [xlen-1:0] pc,
	input  logic [11:0]     csr_addr,
	input  logic            csr_enable,
	input  logic [xlen-1:0] csr_wdata,
	input  logic            inst_ecall,
	input  logic            inst_mret,
	input  logic            lsu_valid,
	input  logic            lsu_ready,
	output logic [xlen-1:0] csr_val,
	output logic [xlen-1:0] csr_jump,
	output logic            csr_jump_en
);

	logic [xlen-1:0] mstatus;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic            commit;

	assign commit = lsu_valid & lsu_ready; // result leaves the stage

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (commit) begin
			if (inst_ecall) begin
				mepc   <= pc;
				mcause <= mcause_ecall;
			end else if (csr_enable) begin
				case (csr_addr)
					csr_mstatus: mstatus <= csr_wdata;
					csr_mtvec:   mtvec   <= csr_wdata;
					csr_mepc:    mepc    <= csr_wdata;
					csr_mcause:  mcause  <= csr_wdata;
					default:     ; // other csrs not implemented
				endcase
			end
		end
	end

	always_comb begin
		case (csr_addr)
			csr_mstatus: csr_val = mstatus;
			csr_mtvec:   csr_val = mtvec;
			csr_mepc:    csr_val = mepc;
			csr_mcause:  csr_val = mcause;
			default:     csr_val = '0;
		endcase
	end

	// trap entry and return
	assign csr_jump_en = inst_ecall | inst_mret;
	assign csr_jump    = inst_ecall ? mtvec : mepc;

endmodule

`default_nettype wire

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top import exu_pkg::*; #(
	parameter int nr_regs = 16
) (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       inst_valid,
	output logic                       inst_ready,
	input  inst_t                      inst,
	input  logic [xlen-1:0]            pc_in,
	input  logic                       wb_en,
	input  logic [$clog2(nr_regs)-1:0] wb_rd,
	input  logic [xlen-1:0]            wb_data,
	output logic                       lsu_valid,
	input  logic                       lsu_ready,
	output logic                       lsu_ren,
	output logic                       lsu_wen,
	output logic [xlen-1:0]            lsu_data,
	output logic [xlen-1:0]            val,
	output logic [$clog2(nr_regs)-1:0] rd,
	output logic [2:0]                 funct3,
	output logic                       reg_wen,
	output logic [xlen-1:0]            jump_addr,
	output logic                       jump_wrong
);

	// decoder to execute
	logic [nr_classes-1:0]      dec_opcode_type;
	logic [$clog2(nr_regs)-1:0] dec_rs1;
	logic [$clog2(nr_regs)-1:0] dec_rs2;
	logic [$clog2(nr_regs)-1:0] dec_rd;
	logic [xlen-1:0]            dec_imm;
	logic [2:0]                 dec_funct3;
	logic                       dec_funct7_5;
	logic                       dec_reg_wen;
	logic                       dec_ecall;
	logic                       dec_mret;
	logic [11:0]                dec_csr_addr;
	logic [xlen-1:0]            src1;
	logic [xlen-1:0]            src2;

	// execute to csr
	logic [xlen-1:0] exu_pc;
	logic [11:0]     exu_csr_addr;
	logic            exu_ecall;
	logic            exu_mret;
	logic            csr_enable;
	logic [xlen-1:0] csr_wdata;
	logic [xlen-1:0] csr_val;
	logic [xlen-1:0] csr_jump;
	logic            csr_jump_en;

	inst_decoder #(.nr_regs(nr_regs)) i_decoder (
		.inst        (inst),
		.opcode_type (dec_opcode_type),
		.rs1         (dec_rs1),
		.rs2         (dec_rs2),
		.rd          (dec_rd),
		.imm         (dec_imm),
		.funct3      (dec_funct3),
		.funct7_5    (dec_funct7_5),
		.reg_wen     (dec_reg_wen),
		.inst_ecall  (dec_ecall),
		.inst_mret   (dec_mret),
		.csr_addr    (dec_csr_addr)
	);

	reg_file #(.nr_regs(nr_regs)) i_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.rs1     (dec_rs1),
		.rs2     (dec_rs2),
		.src1    (src1),
		.src2    (src2),
		.wb_en   (wb_en),
		.wb_rd   (wb_rd),
		.wb_data (wb_data)
	);

	exu #(.nr_regs(nr_regs)) i_exu (
		.clock          (clock),
		.rst_n          (rst_n),
		.opcode_type_in (dec_opcode_type),
		.rd_in          (dec_rd),
		.src1_in        (src1),
		.src2_in        (src2),
		.imm_in         (dec_imm),
		.funct3_in      (dec_funct3),
		.funct7_5_in    (dec_funct7_5),
		.pc_in          (pc_in),
		.reg_wen_in     (dec_reg_wen),
		.inst_ecall_in  (dec_ecall),
		.inst_mret_in   (dec_mret),
		.csr_addr_in    (dec_csr_addr),
		.csr_jump_en    (csr_jump_en),
		.csr_jump       (csr_jump),
		.csr_val        (csr_val),
		.exu_valid      (inst_valid),
		.lsu_ready      (lsu_ready),
		.pc             (exu_pc),
		.rd             (rd),
		.funct3         (funct3),
		.csr_addr       (exu_csr_addr),
		.reg_wen        (reg_wen),
		.inst_ecall     (exu_ecall),
		.inst_mret      (exu_mret),
		.val            (val),
		.lsu_data       (lsu_data),
		.jump_addr      (jump_addr),
		.csr_wdata      (csr_wdata),
		.lsu_ren        (lsu_ren),
		.lsu_wen        (lsu_wen),
		.jump_wrong     (jump_wrong),
		.csr_enable     (csr_enable),
		.exu_ready      (inst_ready),
		.lsu_valid      (lsu_valid)
	);

	csr_unit i_csr_unit (
		.clock       (clock),
		.rst_n       (rst_n),
		.pc          (exu_pc),
		.csr_addr    (exu_csr_addr),
		.csr_enable  (csr_enable),
		.csr_wdata   (csr_wdata),
		.inst_ecall  (exu_ecall),
		.inst_mret   (exu_mret),
		.lsu_valid   (lsu_valid),
		.lsu_ready   (lsu_ready),
		.csr_val     (csr_val),
		.csr_jump    (csr_jump),
		.csr_jump_en (csr_jump_en)
	);

endmodule

`default_nettype wire

// ==== verilog/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu import exu_pkg::*; #(
	parameter int nr_regs = 16
) (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic [nr_classes-1:0]      opcode_type_in,
	input  logic [$clog2(nr_regs)-1:0] rd_in,
	input  logic [xlen-1:0]            src1_in,
	input  logic [xlen-1:0]            src2_in,
	input  logic [xlen-1:0]            imm_in,
	input  logic [2:0]                 funct3_in,
	input  logic                       funct7_5_in,
	input  logic [xlen-1:0]            pc_in,
	input  logic                       reg_wen_in,
	input  logic                       inst_ecall_in,
	input  logic                       inst_mret_in,
	input  logic [11:0]                csr_addr_in,
	input  logic                       csr_jump_en,
	input  logic [xlen-1:0]            csr_jump,
	input  logic [xlen-1:0]            csr_val,
	input  logic                       exu_valid,
	input  logic                       lsu_ready,
	output logic [xlen-1:0]            pc,
	output logic [$clog2(nr_regs)-1:0] rd,
	output logic [2:0]                 funct3,
	output logic [11:0]                csr_addr,
	output logic                       reg_wen,
	output logic                       inst_ecall,
	output logic                       inst_mret,
	output logic [xlen-1:0]            val,
	output logic [xlen-1:0]            lsu_data,
	output logic [xlen-1:0]            jump_addr,
	output logic [xlen-1:0]            csr_wdata,
	output logic                       lsu_ren,
	output logic                       lsu_wen,
	output logic                       jump_wrong,
	output logic                       csr_enable,
	output logic                       exu_ready,
	output logic                       lsu_valid
);

	logic [nr_classes-1:0] opcode_type;
	logic [xlen-1:0]       src1;
	logic [xlen-1:0]       src2;
	logic [xlen-1:0]       imm;
	logic                  funct7_5;
	logic                  accept;
	logic                  jump_wrong_valid;
	logic                  jump_cond;
	logic                  jump_en;
	logic [xlen-1:0]       snpc;
	logic [xlen-1:0]       alu_val;
	logic [xlen-1:0]       sum;
	logic [xlen-1:0]       exu_jump;

	assign accept = exu_valid & exu_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			exu_ready        <= 1'b1;
			lsu_valid        <= 1'b0;
			jump_wrong_valid <= 1'b0;
			opcode_type      <= '0;
			reg_wen          <= 1'b0;
			inst_ecall       <= 1'b0;
			inst_mret        <= 1'b0;
		end else begin
			exu_ready        <= exu_ready & ~exu_valid | ~exu_ready & lsu_valid & lsu_ready;
			lsu_valid        <= lsu_valid & ~lsu_ready | ~lsu_valid & accept;
			jump_wrong_valid <= accept; // first result cycle only
			if (accept) begin
				opcode_type <= opcode_type_in;
				reg_wen     <= reg_wen_in;
				inst_ecall  <= inst_ecall_in;
				inst_mret   <= inst_mret_in;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd       <= rd_in;
			src1     <= src1_in;
			src2     <= src2_in;
			imm      <= imm_in;
			funct3   <= funct3_in;
			funct7_5 <= funct7_5_in;
			pc       <= pc_in;
			csr_addr <= csr_addr_in;
		end
	end

	alu i_alu (
		.opcode_type (opcode_type),
		.funct3      (funct3),
		.funct7_5    (funct7_5),
		.pc          (pc),
		.src1        (src1),
		.src2        (src2),
		.imm         (imm),
		.alu_val     (alu_val),
		.sum         (sum)
	);

	always_comb begin
		case (funct3)
			3'b000:  jump_cond = src1 == src2;
			3'b001:  jump_cond = src1 != src2;
			3'b100:  jump_cond = $signed(src1) < $signed(src2);
			3'b101:  jump_cond = $signed(src1) >= $signed(src2);
			3'b110:  jump_cond = src1 < src2;
			3'b111:  jump_cond = src1 >= src2;
			default: jump_cond = 1'b0;
		endcase
	end

	assign snpc     = pc + 32'd4;
	assign jump_en  = opcode_type[inst_jal] | opcode_type[inst_jalr] |
		opcode_type[inst_beq] & jump_cond;
	assign exu_jump = opcode_type[inst_jalr] ? {sum[xlen-1:1], 1'b0} : sum;

	assign jump_addr  = csr_jump_en ? csr_jump : jump_en ? exu_jump : snpc;
	assign jump_wrong = jump_wrong_valid & (jump_addr != snpc);

	assign csr_enable = opcode_type[inst_csr] & (funct3 != 3'b000); // not ecall/mret
	assign val = (opcode_type[inst_jal] | opcode_type[inst_jalr]) ? snpc :
		csr_enable ? csr_val : alu_val;

	// csrrs sets bits, csrrw replaces
	assign csr_wdata = (funct3 == 3'b010) ? (src1 | csr_val) :
		(funct3 == 3'b001) ? src1 : '0;

	assign lsu_ren  = opcode_type[inst_lw];
	assign lsu_wen  = opcode_type[inst_sw];
	assign lsu_data = src2;

endmodule

`default_nettype wire

// ==== verilog/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

	localparam int xlen       = 32;
	localparam int nr_classes = 10;

	// positions in the one-hot class vector
	localparam int inst_lui   = 0;
	localparam int inst_auipc = 1;
	localparam int inst_jal   = 2;
	localparam int inst_jalr  = 3;
	localparam int inst_beq   = 4; // whole branch group
	localparam int inst_lw    = 5;
	localparam int inst_sw    = 6;
	localparam int inst_addi  = 7; // immediate alu group
	localparam int inst_add   = 8; // register alu group
	localparam int inst_csr   = 9; // csrrw/csrrs, ecall, mret

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_xor,
		alu_or,
		alu_srl,
		alu_sra,
		alu_sll,
		alu_less,
		alu_uless
	} alu_op_t;

	localparam logic [11:0] csr_mstatus = 12'h300;
	localparam logic [11:0] csr_mtvec   = 12'h305;
	localparam logic [11:0] csr_mepc    = 12'h341;
	localparam logic [11:0] csr_mcause  = 12'h342;

	localparam logic [xlen-1:0] mcause_ecall = 32'd11;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_t;

endpackage

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import exu_pkg::*; #(
	parameter int nr_regs = 16
) (
	input  inst_t                      inst,
	output logic [nr_classes-1:0]      opcode_type,
	output logic [$clog2(nr_regs)-1:0] rs1,
	output logic [$clog2(nr_regs)-1:0] rs2,
	output logic [$clog2(nr_regs)-1:0] rd,
	output logic [xlen-1:0]            imm,
	output logic [2:0]                 funct3,
	output logic                       funct7_5,
	output logic                       reg_wen,
	output logic                       inst_ecall,
	output logic                       inst_mret,
	output logic [11:0]                csr_addr
);

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// register fields sit in the same place in every format
	assign rs1      = inst.r_fmt.rs1[$clog2(nr_regs)-1:0];
	assign rs2      = inst.r_fmt.rs2[$clog2(nr_regs)-1:0];
	assign rd       = inst.r_fmt.rd[$clog2(nr_regs)-1:0];
	assign funct3   = inst.r_fmt.funct3;
	assign funct7_5 = inst.r_fmt.funct7[5]; // sub and srai/sra
	assign csr_addr = inst.i_fmt.imm11_0;

	always_comb begin
		opcode_type = '0;
		case (inst.r_fmt.opcode)
			op_lui:    opcode_type[inst_lui]   = 1'b1;
			op_auipc:  opcode_type[inst_auipc] = 1'b1;
			op_jal:    opcode_type[inst_jal]   = 1'b1;
			op_jalr:   opcode_type[inst_jalr]  = 1'b1;
			op_branch: opcode_type[inst_beq]   = 1'b1;
			op_load:   opcode_type[inst_lw]    = 1'b1;
			op_store:  opcode_type[inst_sw]    = 1'b1;
			op_imm:    opcode_type[inst_addi]  = 1'b1;
			op_reg:    opcode_type[inst_add]   = 1'b1;
			op_system: opcode_type[inst_csr]   = 1'b1;
			default:   opcode_type = '0; // unknown opcode, no class
		endcase
	end

	always_comb begin
		if (opcode_type[inst_lui] | opcode_type[inst_auipc])
			imm = {inst.u_fmt.imm31_12, 12'b0};
		else if (opcode_type[inst_jal])
			imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
				inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
		else if (opcode_type[inst_beq])
			imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
				inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
		else if (opcode_type[inst_sw])
			imm = {{20{inst.s_fmt.imm11_5[6]}}, inst.s_fmt.imm11_5, inst.s_fmt.imm4_0};
		else if (|opcode_type)
			imm = {{20{inst.i_fmt.imm11_0[11]}}, inst.i_fmt.imm11_0}; // jalr, lw, alu imm, csr
		else
			imm = '0;
	end

	// no write-back for branches and stores, csr only with a real rd
	assign reg_wen = (|opcode_type) & ~opcode_type[inst_beq] & ~opcode_type[inst_sw] &
		(~opcode_type[inst_csr] | (inst.r_fmt.rd != 5'd0));

	assign inst_ecall = opcode_type[inst_csr] & (funct3 == 3'b000) &
		(inst.i_fmt.imm11_0 == 12'h000);
	assign inst_mret  = opcode_type[inst_csr] & (funct3 == 3'b000) &
		(inst.i_fmt.imm11_0 == 12'h302);

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import exu_pkg::*; #(
	parameter int nr_regs = 16
) (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic [$clog2(nr_regs)-1:0] rs1,
	input  logic [$clog2(nr_regs)-1:0] rs2,
	output logic [xlen-1:0]            src1,
	output logic [xlen-1:0]            src2,
	input  logic                       wb_en,
	input  logic [$clog2(nr_regs)-1:0] wb_rd,
	input  logic [xlen-1:0]            wb_data
);

	logic [xlen-1:0] regs [nr_regs];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < nr_regs; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// x0 reads as zero
	assign src1 = (rs1 == '0) ? '0 : regs[rs1];
	assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
